/* Makefile */
# Verilator simulation of the branch predicting unit

SOURCES := $(shell grep -v '^+' list.f) include/bpu_tb_tasks.svh

all: run

obj_dir/Vtb_bpu: list.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_bpu -f list.f -o Vtb_bpu

run: obj_dir/Vtb_bpu
	./obj_dir/Vtb_bpu | tee sim.log
	@if grep -q "TESTBENCH FAILED" sim.log || ! grep -q "TESTBENCH PASSED" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* list.f */
+incdir+include
logic/bpu_pkg.sv
logic/ftb.sv
logic/bimodal_predictor.sv
logic/return_stack.sv
logic/bpu.sv
verification/tb_bpu.sv

/* logic/bimodal_predictor.sv */
////////////////////
// Bimodal direction predictor of 2-bit saturating counters.
// The counter read is registered, training writes back the carried value.
////////////////////
`timescale 1ns/100ps
`default_nettype none

module bimodal_predictor (
    input  wire                                  clk,
    input  wire                                  rst_n_i,
    input  wire         [bpu_pkg::ADDR_WIDTH-1:0] pc_i,
    input  wire         [bpu_pkg::ADDR_WIDTH-1:0] update_pc_i,
    input  bpu_pkg::dir_update_t                  update_i,
    output logic                                  taken_o,
    output logic        [1:0]                     ctr_bits_o
);

    logic [1:0] pht_q [bpu_pkg::PHT_DEPTH];

    logic [bpu_pkg::PHT_IDX_WIDTH-1:0] read_idx;
    logic [bpu_pkg::PHT_IDX_WIDTH-1:0] write_idx;
    logic [1:0]                        ctr_next;

    assign read_idx  = pc_i[bpu_pkg::PHT_IDX_WIDTH+1:2];
    assign write_idx = update_pc_i[bpu_pkg::PHT_IDX_WIDTH+1:2];

    // One step toward the outcome, saturating at both ends
    always_comb begin
        ctr_next = update_i.ctr_bits;
        if (update_i.branch_taken) begin
            if (update_i.ctr_bits != 2'b11) begin
                ctr_next = update_i.ctr_bits + 2'd1;
            end
        end else if (update_i.ctr_bits != 2'b00) begin
            ctr_next = update_i.ctr_bits - 2'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            // Weakly not-taken
            for (int i = 0; i < bpu_pkg::PHT_DEPTH; i++) begin
                pht_q[i] <= 2'b01;
            end
            ctr_bits_o <= 2'b01;
        end else begin
            ctr_bits_o <= pht_q[read_idx];
            if (update_i.valid && update_i.is_conditional) begin
                pht_q[write_idx] <= ctr_next;
            end
        end
    end

    assign taken_o = ctr_bits_o[1];

endmodule

`default_nettype wire

/* logic/bpu.sv */
////////////////////
// Branch predicting unit top. Gives the FTQ a next-line block in P0 and
// an FTB based block plus redirect in P1; decodes FTQ training records.
////////////////////
`timescale 1ns/100ps
`default_nettype none

module bpu (
    input  wire                             clk,
    input  wire                             rst_n_i,
    input  wire                             backend_flush_i,
    input  wire  [bpu_pkg::ADDR_WIDTH-1:0]  pc_i,
    input  wire                             ftq_full_i,
    input  bpu_pkg::ftq_bpu_meta_t          ftq_meta_i,
    output bpu_pkg::ftq_block_t             ftq_p0_o,
    output bpu_pkg::ftq_block_t             ftq_p1_o,
    output bpu_pkg::bpu_ftq_meta_t          ftq_meta_o,
    output logic                            main_redirect_o,
    output logic [bpu_pkg::ADDR_WIDTH-1:0]  main_redirect_pc_o
);

    localparam int LEN_MSB = $clog2(bpu_pkg::FETCH_WIDTH) + 2;

    logic [bpu_pkg::ADDR_WIDTH-1:0]    p1_pc;
    logic                              flush_delay;
    logic                              full_delay;
    logic                              ftb_hit;
    logic [bpu_pkg::FTB_WAY_WIDTH-1:0] ftb_hit_index;
    bpu_pkg::ftb_entry_t               ftb_entry;
    logic                              predict_taken;
    logic [1:0]                        predict_ctr;
    logic [bpu_pkg::ADDR_WIDTH-1:0]    ras_top;
    logic                              page_cut;
    logic [11:0]                       page_dist;

    ////////////////////
    // P0 next-line block
    ////////////////////
    // Four instructions would run past the 4 KiB page
    assign page_cut  = pc_i[11:0] > 12'hff0;
    assign page_dist = 12'h000 - pc_i[11:0];

    always_comb begin
        ftq_p0_o = '0;
        if (!ftq_full_i) begin
            ftq_p0_o.valid    = 1'b1;
            ftq_p0_o.start_pc = pc_i;
            ftq_p0_o.length   = page_cut ? page_dist[LEN_MSB:2] :
                                           3'(bpu_pkg::FETCH_WIDTH);
            // A cut block ends at the page edge, inside the line
            ftq_p0_o.is_cross_cacheline = (pc_i[3:2] != 2'b00) && !page_cut;
        end
    end

    ////////////////////
    // P1 block and redirect
    ////////////////////
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            flush_delay <= 1'b0;
            full_delay  <= 1'b0;
        end else begin
            flush_delay <= backend_flush_i || (main_redirect_o && !full_delay);
            full_delay  <= ftq_full_i;
        end
    end

    always_ff @(posedge clk) begin
        p1_pc <= pc_i;
    end

    assign main_redirect_o = ftb_hit && !flush_delay && !full_delay;

    always_comb begin
        ftq_p1_o = '0;
        if (main_redirect_o) begin
            ftq_p1_o.valid              = 1'b1;
            ftq_p1_o.start_pc           = p1_pc;
            // Wrapped 3-bit difference stays within one block
            ftq_p1_o.length             = ftb_entry.fall_through_address[LEN_MSB:2] -
                                          p1_pc[LEN_MSB:2];
            ftq_p1_o.is_cross_cacheline = ftb_entry.is_cross_cacheline;
            ftq_p1_o.predicted_taken    =
                (ftb_entry.branch_type == bpu_pkg::BRANCH_TYPE_COND) ? predict_taken : 1'b1;
            ftq_p1_o.predict_valid      = 1'b1;
        end
    end

    always_comb begin
        case (ftb_entry.branch_type)
            bpu_pkg::BRANCH_TYPE_COND: begin
                main_redirect_pc_o = predict_taken ? ftb_entry.jump_target_address :
                                                     ftb_entry.fall_through_address;
            end
            bpu_pkg::BRANCH_TYPE_RET: begin
                main_redirect_pc_o = ras_top;
            end
            default: begin
                main_redirect_pc_o = ftb_entry.jump_target_address;
            end
        endcase
    end

    // Meta the FTQ hands back on training
    always_comb begin
        ftq_meta_o.valid         = ftb_hit;
        ftq_meta_o.ftb_hit       = ftb_hit;
        ftq_meta_o.ftb_hit_index = ftb_hit_index;
        ftq_meta_o.ctr_bits      = predict_ctr;
    end

    ////////////////////
    // Training decode
    ////////////////////
    logic                 mispredict;
    logic                 dirty_hit;
    logic                 ftb_update_valid;
    bpu_pkg::ftb_entry_t  ftb_update_entry;
    bpu_pkg::dir_update_t dir_update;
    logic                 ras_push;
    logic                 ras_pop;

    assign mispredict = ftq_meta_i.predicted_taken ^ ftq_meta_i.is_taken;
    assign dirty_hit  = ftq_meta_i.ftb_dirty && ftq_meta_i.ftb_hit;

    // First taken resolution installs, a polluted entry gets dropped
    assign ftb_update_valid = ftq_meta_i.valid &&
                              ((mispredict && !ftq_meta_i.ftb_hit) || dirty_hit);

    always_comb begin
        ftb_update_entry.valid                = !dirty_hit;
        ftb_update_entry.tag                  =
            ftq_meta_i.start_pc[bpu_pkg::ADDR_WIDTH-1:bpu_pkg::FTB_IDX_WIDTH+2];
        ftb_update_entry.branch_type          = ftq_meta_i.branch_type;
        ftb_update_entry.is_cross_cacheline   = ftq_meta_i.is_cross_cacheline;
        ftb_update_entry.jump_target_address  = ftq_meta_i.jump_target_address;
        ftb_update_entry.fall_through_address = ftq_meta_i.fall_through_address;
    end

    always_comb begin
        dir_update.valid          = ftq_meta_i.valid;
        dir_update.is_conditional = ftq_meta_i.branch_type == bpu_pkg::BRANCH_TYPE_COND;
        dir_update.branch_taken   = ftq_meta_i.is_taken;
        dir_update.ctr_bits       = ftq_meta_i.ctr_bits;
    end

    assign ras_push = ftq_meta_i.valid && (ftq_meta_i.branch_type == bpu_pkg::BRANCH_TYPE_CALL);
    assign ras_pop  = ftq_meta_i.valid && (ftq_meta_i.branch_type == bpu_pkg::BRANCH_TYPE_RET);

    ftb u_ftb (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .query_pc_i     (pc_i),
        .update_valid_i (ftb_update_valid),
        .update_pc_i    (ftq_meta_i.start_pc),
        .update_way_i   (ftq_meta_i.ftb_hit_index),
        .update_dirty_i (dirty_hit),
        .update_entry_i (ftb_update_entry),
        .query_entry_o  (ftb_entry),
        .hit_o          (ftb_hit),
        .hit_index_o    (ftb_hit_index)
    );

    bimodal_predictor u_bimodal_predictor (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .pc_i        (pc_i),
        .update_pc_i (ftq_meta_i.start_pc),
        .update_i    (dir_update),
        .taken_o     (predict_taken),
        .ctr_bits_o  (predict_ctr)
    );

    return_stack u_return_stack (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .push_i      (ras_push),
        .push_addr_i (ftq_meta_i.fall_through_address),
        .pop_i       (ras_pop),
        .top_addr_o  (ras_top)
    );

    // A flush silences the redirect of the following cycle
    a_no_redirect_after_flush: assert property (
        @(posedge clk) disable iff (!rst_n_i) backend_flush_i |=> !main_redirect_o
    );

    a_no_p0_when_full: assert property (
        @(posedge clk) disable iff (!rst_n_i) !(ftq_full_i && ftq_p0_o.valid)
    );

endmodule

`default_nettype wire

/* logic/bpu_pkg.sv */
////////////////////
// Shared sizes, branch type codes and packed records of the branch
// predicting unit. Files reach everything here by scoped names.
////////////////////
`default_nettype none

package bpu_pkg;

    localparam int ADDR_WIDTH  = 32;
    localparam int FETCH_WIDTH = 4;

    // FTB geometry: set index pc[5:2], tag pc[31:6]
    localparam int FTB_NSET      = 16;
    localparam int FTB_NWAY      = 2;
    localparam int FTB_IDX_WIDTH = $clog2(FTB_NSET);
    localparam int FTB_WAY_WIDTH = $clog2(FTB_NWAY);
    localparam int FTB_TAG_WIDTH = ADDR_WIDTH - FTB_IDX_WIDTH - 2;

    // Direction table indexed by pc[9:2]
    localparam int PHT_DEPTH     = 256;
    localparam int PHT_IDX_WIDTH = $clog2(PHT_DEPTH);

    localparam int RAS_DEPTH     = 8;
    localparam int RAS_PTR_WIDTH = $clog2(RAS_DEPTH);

    // Block length counts 0 to FETCH_WIDTH
    localparam int LEN_WIDTH = $clog2(FETCH_WIDTH) + 1;

    localparam logic [1:0] BRANCH_TYPE_COND   = 2'd0;
    localparam logic [1:0] BRANCH_TYPE_CALL   = 2'd1;
    localparam logic [1:0] BRANCH_TYPE_RET    = 2'd2;
    localparam logic [1:0] BRANCH_TYPE_UNCOND = 2'd3;

    typedef struct packed {
        logic                     valid;
        logic [FTB_TAG_WIDTH-1:0] tag;
        logic [1:0]               branch_type;
        logic                     is_cross_cacheline;
        logic [ADDR_WIDTH-1:0]    jump_target_address;
        logic [ADDR_WIDTH-1:0]    fall_through_address;
    } ftb_entry_t;

    typedef struct packed {
        logic                  valid;
        logic [ADDR_WIDTH-1:0] start_pc;
        logic [LEN_WIDTH-1:0]  length;
        logic                  is_cross_cacheline;
        logic                  predicted_taken;
        logic                  predict_valid;
    } ftq_block_t;

    // Prediction meta kept by the FTQ until the branch resolves
    typedef struct packed {
        logic                     valid;
        logic                     ftb_hit;
        logic [FTB_WAY_WIDTH-1:0] ftb_hit_index;
        logic [1:0]               ctr_bits;
    } bpu_ftq_meta_t;

    // Training record returned by the FTQ
    typedef struct packed {
        logic                     valid;
        logic [ADDR_WIDTH-1:0]    start_pc;
        logic [1:0]               branch_type;
        logic                     is_taken;
        logic                     predicted_taken;
        logic                     ftb_hit;
        logic [FTB_WAY_WIDTH-1:0] ftb_hit_index;
        logic                     ftb_dirty;
        logic                     is_cross_cacheline;
        logic [ADDR_WIDTH-1:0]    jump_target_address;
        logic [ADDR_WIDTH-1:0]    fall_through_address;
        logic [1:0]               ctr_bits;
    } ftq_bpu_meta_t;

    typedef struct packed {
        logic       valid;
        logic       is_conditional;
        logic       branch_taken;
        logic [1:0] ctr_bits;
    } dir_update_t;

endpackage

`default_nettype wire

/* logic/ftb.sv */
////////////////////
// Set-associative fetch target buffer. Lookup result is registered and
// belongs to the previous query PC. Installs fill round-robin per set.
////////////////////
`timescale 1ns/100ps
`default_nettype none

module ftb (
    input  wire                                      clk,
    input  wire                                      rst_n_i,
    input  wire        [bpu_pkg::ADDR_WIDTH-1:0]     query_pc_i,
    input  wire                                      update_valid_i,
    input  wire        [bpu_pkg::ADDR_WIDTH-1:0]     update_pc_i,
    input  wire        [bpu_pkg::FTB_WAY_WIDTH-1:0]  update_way_i,
    input  wire                                      update_dirty_i,
    input  bpu_pkg::ftb_entry_t                      update_entry_i,
    output bpu_pkg::ftb_entry_t                      query_entry_o,
    output logic                                     hit_o,
    output logic       [bpu_pkg::FTB_WAY_WIDTH-1:0]  hit_index_o
);

    bpu_pkg::ftb_entry_t entries_q [bpu_pkg::FTB_NSET][bpu_pkg::FTB_NWAY];

    logic [bpu_pkg::FTB_NSET-1:0][bpu_pkg::FTB_NWAY-1:0]      valid_q;
    logic [bpu_pkg::FTB_NSET-1:0][bpu_pkg::FTB_WAY_WIDTH-1:0] rr_q;

    logic [bpu_pkg::FTB_IDX_WIDTH-1:0] query_set;
    logic [bpu_pkg::FTB_TAG_WIDTH-1:0] query_tag;
    logic [bpu_pkg::FTB_IDX_WIDTH-1:0] update_set;
    logic [bpu_pkg::FTB_WAY_WIDTH-1:0] write_way;
    logic [bpu_pkg::FTB_NWAY-1:0]      way_match;
    logic [bpu_pkg::FTB_WAY_WIDTH-1:0] match_way;
    bpu_pkg::ftb_entry_t               match_entry;

    assign query_set  = query_pc_i[bpu_pkg::FTB_IDX_WIDTH+1:2];
    assign query_tag  = query_pc_i[bpu_pkg::ADDR_WIDTH-1:bpu_pkg::FTB_IDX_WIDTH+2];
    assign update_set = update_pc_i[bpu_pkg::FTB_IDX_WIDTH+1:2];

    // Dirty entries are rewritten in place, new ones go to the RR way
    assign write_way = update_dirty_i ? update_way_i : rr_q[update_set];

    ////////////////////
    // Lookup
    ////////////////////
    always_comb begin
        way_match   = '0;
        match_way   = '0;
        match_entry = entries_q[query_set][0];
        for (int w = 0; w < bpu_pkg::FTB_NWAY; w++) begin
            way_match[w] = valid_q[query_set][w] &&
                           (entries_q[query_set][w].tag == query_tag);
            if (way_match[w]) begin
                match_way   = w[bpu_pkg::FTB_WAY_WIDTH-1:0];
                match_entry = entries_q[query_set][w];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hit_o <= 1'b0;
        end else begin
            hit_o <= |way_match;
        end
    end

    always_ff @(posedge clk) begin
        query_entry_o <= match_entry;
        hit_index_o   <= match_way;
    end

    ////////////////////
    // Update
    ////////////////////
    always_ff @(posedge clk) begin
        if (update_valid_i) begin
            entries_q[update_set][write_way] <= update_entry_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            rr_q    <= '0;
        end else if (update_valid_i) begin
            valid_q[update_set][write_way] <= update_entry_i.valid;
            if (!update_dirty_i) begin
                rr_q[update_set] <= rr_q[update_set] + 1'b1;
            end
        end
    end

    // Installs happen only on a miss, so a tag lives in one way at most
    a_single_way_hit: assert property (
        @(posedge clk) disable iff (!rst_n_i) !(&way_match)
    );

endmodule

`default_nettype wire

/* logic/return_stack.sv */
////////////////////
// Circular return address stack. Calls push the return address,
// returns pop it; overflow overwrites the oldest entry.
////////////////////
`timescale 1ns/100ps
`default_nettype none

module return_stack (
    input  wire                            clk,
    input  wire                            rst_n_i,
    input  wire                            push_i,
    input  wire [bpu_pkg::ADDR_WIDTH-1:0]  push_addr_i,
    input  wire                            pop_i,
    output logic [bpu_pkg::ADDR_WIDTH-1:0] top_addr_o
);

    logic [bpu_pkg::ADDR_WIDTH-1:0]    stack_q [bpu_pkg::RAS_DEPTH];
    logic [bpu_pkg::RAS_PTR_WIDTH-1:0] ptr_q;
    logic [bpu_pkg::RAS_PTR_WIDTH-1:0] top_ptr;

    // Pointer names the next free slot
    assign top_ptr    = ptr_q - 1'b1;
    assign top_addr_o = stack_q[top_ptr];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ptr_q <= '0;
        end else if (push_i) begin
            ptr_q <= ptr_q + 1'b1;
        end else if (pop_i) begin
            ptr_q <= top_ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            stack_q[ptr_q] <= push_addr_i;
        end
    end

    // A training record is either a call or a return, never both
    a_no_push_pop: assert property (
        @(posedge clk) disable iff (!rst_n_i) !(push_i && pop_i)
    );

endmodule

`default_nettype wire

/* include/bpu_tb_tasks.svh */
////////////////////
// Testbench helpers for the branch predicting unit. Stimulus, P1
// sampling, value checks and small reference models of the rules.
// Included inside the testbench module body.
////////////////////
`ifndef BPU_TB_TASKS_SVH
`define BPU_TB_TASKS_SVH

task automatic check_value(input string what, input logic [63:0] expected,
                           input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
        errors++;
        test_errors++;
        $display("MISMATCH test=%s check=%s expected=0x%0h actual=0x%0h",
                 test_name, what, expected, actual);
    end
endtask

task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
endtask

task automatic end_test();
    tests_run++;
    $display("test %-12s finished with %0d errors", test_name, test_errors);
endtask

// Saturating 2-bit counter, one step toward the outcome
function automatic logic [1:0] ctr_step(input logic [1:0] ctr, input logic taken);
    if (taken) begin
        return (ctr == 2'b11) ? ctr : ctr + 2'b01;
    end
    return (ctr == 2'b00) ? ctr : ctr - 2'b01;
endfunction

function automatic bpu_pkg::ftq_block_t p0_expected(input logic [31:0] pc, input logic full);
    bpu_pkg::ftq_block_t blk;
    int unsigned         offset;
    blk    = '0;
    offset = {20'd0, pc[11:0]};
    if (!full) begin
        blk.valid    = 1'b1;
        blk.start_pc = pc;
        if (offset > 32'hff0) begin
            // Block stops at the 4 KiB page end
            blk.length = 3'((32'd4096 - offset) / 32'd4);
        end else begin
            blk.length             = 3'd4;
            blk.is_cross_cacheline = (pc[3:2] != 2'b00);
        end
    end
    return blk;
endfunction

// Entry cross flag follows make_record below
function automatic bpu_pkg::ftq_block_t p1_expected(input logic [31:0] pc,
                                                    input logic [31:0] fall_through,
                                                    input logic taken);
    bpu_pkg::ftq_block_t blk;
    blk                    = '0;
    blk.valid              = 1'b1;
    blk.start_pc           = pc;
    blk.length             = fall_through[4:2] - pc[4:2];
    blk.is_cross_cacheline = (pc[3:2] != 2'b00);
    blk.predicted_taken    = taken;
    blk.predict_valid      = 1'b1;
    return blk;
endfunction

function automatic bpu_pkg::ftq_bpu_meta_t make_record(
    input logic [31:0] pc, input logic [1:0] btype, input logic taken,
    input logic pred_taken, input logic hit, input logic [bpu_pkg::FTB_WAY_WIDTH-1:0] way,
    input logic [31:0] jump, input logic [31:0] fall_through, input logic [1:0] ctr);
    bpu_pkg::ftq_bpu_meta_t rec;
    rec                      = '0;
    rec.valid                = 1'b1;
    rec.start_pc             = pc;
    rec.branch_type          = btype;
    rec.is_taken             = taken;
    rec.predicted_taken      = pred_taken;
    rec.ftb_hit              = hit;
    rec.ftb_hit_index        = way;
    rec.is_cross_cacheline   = (pc[3:2] != 2'b00);
    rec.jump_target_address  = jump;
    rec.fall_through_address = fall_through;
    rec.ctr_bits             = ctr;
    return rec;
endfunction

// One-cycle training pulse, the RAS model follows calls and returns
task automatic train(input bpu_pkg::ftq_bpu_meta_t rec);
    @(posedge clk);
    ftq_meta_i <= rec;
    @(posedge clk);
    ftq_meta_i <= '0;
    if (rec.branch_type == bpu_pkg::BRANCH_TYPE_CALL) begin
        ras_model.push_back(rec.fall_through_address);
    end else if (rec.branch_type == bpu_pkg::BRANCH_TYPE_RET && ras_model.size() > 0) begin
        void'(ras_model.pop_back());
    end
endtask

task automatic drive_p0(input logic [31:0] pc, input logic full);
    @(posedge clk);
    pc_i       <= pc;
    ftq_full_i <= full;
    @(negedge clk);
    check_value("p0 block", p0_expected(pc, full), ftq_p0_o);
endtask

task automatic sample_p1();
    s_redirect    = main_redirect_o;
    s_redirect_pc = main_redirect_pc_o;
    s_p1          = ftq_p1_o;
    s_meta        = ftq_meta_o;
endtask

// Query one PC, then sample its P1 result mid-cycle
task automatic query(input logic [31:0] pc, input logic full, input logic flush);
    @(posedge clk);
    pc_i            <= pc;
    ftq_full_i      <= full;
    backend_flush_i <= flush;
    @(posedge clk);
    pc_i            <= IDLE_PC;
    ftq_full_i      <= 1'b0;
    backend_flush_i <= 1'b0;
    @(negedge clk);
    sample_p1();
endtask

task automatic expect_redirect(input string what, input logic [31:0] pc,
                               input logic [31:0] target, input logic taken,
                               input logic [31:0] fall_through);
    query(pc, 1'b0, 1'b0);
    check_value({what, " redirect"}, 64'd1, s_redirect);
    check_value({what, " target"}, target, s_redirect_pc);
    check_value({what, " p1 block"}, p1_expected(pc, fall_through, taken), s_p1);
endtask

task automatic expect_miss(input string what, input logic [31:0] pc,
                           input logic full, input logic flush);
    query(pc, full, flush);
    check_value({what, " redirect"}, 64'd0, s_redirect);
    check_value({what, " p1 block"}, 64'd0, s_p1);
endtask

`endif

/* verification/tb_bpu.sv */
////////////////////
// Directed testbench of the branch predicting unit. Runs P0, FTB,
// direction, RAS, suppression and round-robin tests in turn.
////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_bpu;

    localparam int NUM_TESTS  = 6;
    localparam int CLK_PERIOD = 20;

    localparam logic [31:0] IDLE_PC     = 32'h0000_0000;
    // Conditional branch, set 2
    localparam logic [31:0] PC_A        = 32'h0000_1208;
    localparam logic [31:0] TARGET_A    = 32'h0000_2000;
    localparam logic [31:0] FT_A        = 32'h0000_1214;
    // Call in set 6 with a wrapping block length, return in set 8
    localparam logic [31:0] CALL_PC     = 32'h0000_3018;
    localparam logic [31:0] CALL_TARGET = 32'h0000_5000;
    localparam logic [31:0] FT_CALL     = 32'h0000_3024;
    localparam logic [31:0] RET_PC      = 32'h0000_4020;
    localparam logic [31:0] FT_RET      = 32'h0000_4024;

    logic                   clk;
    logic                   rst_n_i;
    logic                   backend_flush_i;
    logic [31:0]            pc_i;
    logic                   ftq_full_i;
    bpu_pkg::ftq_bpu_meta_t ftq_meta_i;
    bpu_pkg::ftq_block_t    ftq_p0_o;
    bpu_pkg::ftq_block_t    ftq_p1_o;
    bpu_pkg::bpu_ftq_meta_t ftq_meta_o;
    logic                   main_redirect_o;
    logic [31:0]            main_redirect_pc_o;

    // Sampled P1 outputs
    logic                   s_redirect;
    logic [31:0]            s_redirect_pc;
    bpu_pkg::ftq_block_t    s_p1;
    bpu_pkg::bpu_ftq_meta_t s_meta;

    string       test_name;
    int          errors;
    int          test_errors;
    int          checks;
    int          tests_run;
    integer      seed;
    logic [1:0]  ctr_a;
    logic [31:0] ras_model [$];

    `include "bpu_tb_tasks.svh"

    bpu uut (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .backend_flush_i    (backend_flush_i),
        .pc_i               (pc_i),
        .ftq_full_i         (ftq_full_i),
        .ftq_meta_i         (ftq_meta_i),
        .ftq_p0_o           (ftq_p0_o),
        .ftq_p1_o           (ftq_p1_o),
        .ftq_meta_o         (ftq_meta_o),
        .main_redirect_o    (main_redirect_o),
        .main_redirect_pc_o (main_redirect_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (NUM_TESTS * 200) @(posedge clk);
        $display("Timeout: the tests did not complete within %0d cycles", NUM_TESTS * 200);
        $display("TESTBENCH FAILED");
        $finish;
    end

    ////////////////////
    // Tests
    ////////////////////
    task automatic test_p0_block();
        logic [31:0] pc;
        start_test("p0_block");
        for (int i = 0; i < 24; i++) begin
            pc = $random(seed);
            drive_p0({pc[31:2], 2'b00}, 1'b0);
        end
        drive_p0(32'h0000_0ff4, 1'b0);
        drive_p0(32'h7654_3ff8, 1'b0);
        drive_p0(32'h0000_affc, 1'b0);
        drive_p0(32'h1234_5ff0, 1'b0);
        drive_p0(32'h0000_1000, 1'b0);
        drive_p0(32'h0000_2004, 1'b0);
        // Queue full blanks the whole block
        for (int i = 0; i < 4; i++) begin
            pc = $random(seed);
            drive_p0({pc[31:2], 2'b00}, 1'b1);
        end
        @(posedge clk);
        pc_i       <= IDLE_PC;
        ftq_full_i <= 1'b0;
        end_test();
    endtask

    task automatic test_ftb_install();
        start_test("ftb_install");
        expect_miss("untrained", PC_A, 1'b0, 1'b0);
        check_value("untrained meta", 64'd0, s_meta.valid);
        // Taken branch predicted not-taken, with the counter read at lookup
        train(make_record(PC_A, bpu_pkg::BRANCH_TYPE_COND, 1'b1, 1'b0, 1'b0, 1'b0,
                          TARGET_A, FT_A, ctr_a));
        ctr_a = ctr_step(ctr_a, 1'b1);
        expect_redirect("installed", PC_A, ctr_a[1] ? TARGET_A : FT_A, ctr_a[1], FT_A);
        check_value("meta hit", 64'd1, s_meta.ftb_hit);
        check_value("meta way", 64'd0, s_meta.ftb_hit_index);
        check_value("meta ctr", ctr_a, s_meta.ctr_bits);
        end_test();
    endtask

    task automatic test_direction();
        logic [4:0] outcomes;
        start_test("direction");
        // Outcomes from bit 0 up
        outcomes = 5'b00110;
        for (int i = 0; i < 5; i++) begin
            train(make_record(PC_A, bpu_pkg::BRANCH_TYPE_COND, outcomes[i], ctr_a[1],
                              1'b1, 1'b0, TARGET_A, FT_A, ctr_a));
            ctr_a = ctr_step(ctr_a, outcomes[i]);
            expect_redirect("trained", PC_A, ctr_a[1] ? TARGET_A : FT_A, ctr_a[1], FT_A);
            check_value("meta ctr", ctr_a, s_meta.ctr_bits);
        end
        end_test();
    endtask

    task automatic test_call_return();
        start_test("call_return");
        // The call install pushes too
        train(make_record(CALL_PC, bpu_pkg::BRANCH_TYPE_CALL, 1'b1, 1'b0, 1'b0, 1'b0,
                          CALL_TARGET, FT_CALL, 2'b01));
        train(make_record(CALL_PC, bpu_pkg::BRANCH_TYPE_CALL, 1'b1, 1'b1, 1'b1, 1'b0,
                          CALL_TARGET, 32'h0000_7100, 2'b01));
        train(make_record(RET_PC, bpu_pkg::BRANCH_TYPE_RET, 1'b1, 1'b0, 1'b0, 1'b0,
                          32'h0, FT_RET, 2'b01));
        train(make_record(CALL_PC, bpu_pkg::BRANCH_TYPE_CALL, 1'b1, 1'b1, 1'b1, 1'b0,
                          CALL_TARGET, 32'h0000_7200, 2'b01));
        expect_redirect("call", CALL_PC, CALL_TARGET, 1'b1, FT_CALL);
        expect_redirect("return", RET_PC, 32'h0000_7200, 1'b1, FT_RET);
        train(make_record(RET_PC, bpu_pkg::BRANCH_TYPE_RET, 1'b1, 1'b1, 1'b1, 1'b0,
                          32'h0, FT_RET, 2'b01));
        expect_redirect("return after pop", RET_PC, ras_model[$], 1'b1, FT_RET);
        end_test();
    endtask

    task automatic test_suppression();
        bpu_pkg::ftq_bpu_meta_t rec;
        logic [31:0]            target;
        start_test("suppression");
        target = ctr_a[1] ? TARGET_A : FT_A;
        expect_miss("flush", PC_A, 1'b0, 1'b1);
        expect_miss("full", PC_A, 1'b1, 1'b0);
        // Same hit PC twice in a row
        @(posedge clk);
        pc_i <= PC_A;
        @(posedge clk);
        pc_i <= PC_A;
        @(negedge clk);
        sample_p1();
        check_value("first of pair", 64'd1, s_redirect);
        check_value("first target", target, s_redirect_pc);
        @(posedge clk);
        pc_i <= IDLE_PC;
        @(negedge clk);
        sample_p1();
        check_value("second of pair", 64'd0, s_redirect);
        rec = make_record(PC_A, bpu_pkg::BRANCH_TYPE_COND, 1'b0, ctr_a[1], 1'b1, 1'b0,
                          TARGET_A, FT_A, ctr_a);
        rec.ftb_dirty = 1'b1;
        train(rec);
        ctr_a = ctr_step(ctr_a, 1'b0);
        expect_miss("invalidated", PC_A, 1'b0, 1'b0);
        end_test();
    endtask

    task automatic test_round_robin();
        logic [31:0] pc;
        start_test("round_robin");
        // Three tags in set 12
        for (int i = 1; i <= 3; i++) begin
            pc = (32'(i) << 16) | 32'h0000_0030;
            train(make_record(pc, bpu_pkg::BRANCH_TYPE_UNCOND, 1'b1, 1'b0, 1'b0, 1'b0,
                              pc + 32'h100, pc + 32'h4, 2'b01));
        end
        // Ways fill 0, 1, then 0 again
        expect_miss("evicted tag", 32'h0001_0030, 1'b0, 1'b0);
        expect_redirect("second tag", 32'h0002_0030, 32'h0002_0130, 1'b1, 32'h0002_0034);
        check_value("second way", 64'd1, s_meta.ftb_hit_index);
        expect_redirect("third tag", 32'h0003_0030, 32'h0003_0130, 1'b1, 32'h0003_0034);
        check_value("third way", 64'd0, s_meta.ftb_hit_index);
        end_test();
    endtask

    ////////////////////
    // Sequence
    ////////////////////
    initial begin
        seed            = 95893;
        errors          = 0;
        test_errors     = 0;
        checks          = 0;
        tests_run       = 0;
        ctr_a           = 2'b01;
        rst_n_i         = 1'b0;
        backend_flush_i = 1'b0;
        pc_i            = IDLE_PC;
        ftq_full_i      = 1'b0;
        ftq_meta_i      = '0;
        repeat (16) @(posedge clk);
        rst_n_i <= 1'b1;

        test_p0_block();
        test_ftb_install();
        test_direction();
        test_call_return();
        test_suppression();
        test_round_robin();

        repeat (4) @(posedge clk);
        $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
